// ==== logic/pss_peak_pkg.sv ====
package pss_peak_pkg;

    // magnitude samples from the correlators
    localparam int SAMPLE_W = 16;
    typedef logic [SAMPLE_W-1:0] sample_t;

    localparam int SCORE_W = 16;
    // sample index wraps around
    localparam int TS_W    = 14;
    localparam int CH_W    = 2;
    localparam int DROP_W  = 16;

    // threshold is DETECTION_FACTOR times the window mean
    localparam int DETECTION_FACTOR = 16;

    // fixed noise floor, a peak must exceed it
    localparam int NOISE_LIMIT = 2 ** (SAMPLE_W / 2);

    localparam int ENTRY_W = CH_W + TS_W + SCORE_W;

    typedef struct packed {
        logic [CH_W-1:0]    chan;
        logic [TS_W-1:0]    index;
        logic [SCORE_W-1:0] score;
    } log_fields_t;

    // the log stores the raw word, producers and consumers use the fields
    typedef union packed {
        logic [ENTRY_W-1:0] raw;
        log_fields_t        fld;
    } log_entry_t;

endpackage

// ==== logic/peak_detector.sv ====
`timescale 1ns/1ps

module peak_detector #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  pss_peak_pkg::sample_t             sample_i,
    input  logic                              valid_i,
    output logic                              peak_o,
    output logic [pss_peak_pkg::SCORE_W-1:0]  score_o
);

    import pss_peak_pkg::*;

    localparam int WIN_SHIFT    = $clog2(WINDOW_LEN);
    localparam int FACTOR_SHIFT = $clog2(DETECTION_FACTOR);
    localparam int SUM_W        = SAMPLE_W + WIN_SHIFT;
    localparam int THR_W        = SUM_W + FACTOR_SHIFT;
    localparam int WARM_W       = WIN_SHIFT + 1;

    sample_t            win_q [WINDOW_LEN];
    logic [SUM_W-1:0]   sum_q;
    logic [WARM_W-1:0]  warm_q;

    logic [THR_W-1:0]   thr;
    logic [THR_W-1:0]   x_wide;
    logic               warmed;
    logic               above_thr;
    logic               above_noise;
    logic               hit;

    // sum_q always holds the WINDOW_LEN samples before the current one
    assign thr    = {sum_q, {FACTOR_SHIFT{1'b0}}} >> WIN_SHIFT;
    assign x_wide = THR_W'(sample_i);

    assign warmed      = warm_q == WARM_W'(WINDOW_LEN);
    assign above_thr   = x_wide > thr;
    assign above_noise = sample_i > SAMPLE_W'(NOISE_LIMIT);
    assign hit         = warmed && above_thr && above_noise;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int i = 0; i < WINDOW_LEN; i++) begin
                win_q[i] <= '0;
            end
        end else if (valid_i) begin
            win_q[0] <= sample_i;
            for (int i = 1; i < WINDOW_LEN; i++) begin
                win_q[i] <= win_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sum_q  <= '0;
            warm_q <= '0;
        end else if (valid_i) begin
            sum_q <= sum_q + SUM_W'(sample_i) - SUM_W'(win_q[WINDOW_LEN-1]);
            if (!warmed) begin
                warm_q <= warm_q + 1'b1;
            end
        end
    end

    // peak_o is a single-cycle pulse tied to the sample that caused it
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            peak_o  <= 1'b0;
            score_o <= '0;
        end else if (valid_i && hit) begin
            peak_o  <= 1'b1;
            score_o <= SCORE_W'(x_wide - thr);
        end else begin
            peak_o  <= 1'b0;
            score_o <= '0;
        end
    end

    // the reporter logs score_o only on a peak, so it must stay clean otherwise
    a_score_idle: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !peak_o |-> score_o == '0
    );

endmodule

// ==== logic/peak_reporter.sv ====
`timescale 1ns/1ps

module peak_reporter #(
    parameter int CHANNEL = 0
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic                              valid_i,
    input  logic                              peak_i,
    input  logic [pss_peak_pkg::SCORE_W-1:0]  score_i,
    output logic                              req_o,
    input  logic                              ack_i,
    output pss_peak_pkg::log_entry_t          entry_o,
    output logic                              drop_o
);

    import pss_peak_pkg::*;

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_REQ     = 2'd1;
    localparam logic [1:0] S_RELEASE = 2'd2;

    logic [1:0]        state_q;
    logic [TS_W-1:0]   ts_cnt_q;
    logic [TS_W-1:0]   ts_lag_q;
    log_entry_t        entry_q;
    logic              capture;

    assign capture = peak_i && (state_q == S_IDLE);
    assign req_o   = state_q == S_REQ;
    assign entry_o = entry_q;

    // index of the sample the detector is currently reporting on
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ts_cnt_q <= '0;
            ts_lag_q <= '0;
        end else if (valid_i) begin
            ts_cnt_q <= ts_cnt_q + 1'b1;
            ts_lag_q <= ts_cnt_q;
        end
    end

    // four-phase requester, busy from capture until ack falls
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= S_IDLE;
            drop_o  <= 1'b0;
        end else begin
            drop_o <= peak_i && (state_q != S_IDLE);
            case (state_q)
                S_IDLE: begin
                    if (peak_i) begin
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (ack_i) begin
                        state_q <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!ack_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            entry_q.fld.chan  <= CH_W'(CHANNEL);
            entry_q.fld.index <= ts_lag_q;
            entry_q.fld.score <= score_i;
        end
    end

    // the arbiter may sample the entry on any cycle of the request
    a_entry_stable: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        req_o && $past(req_o) |-> entry_o == $past(entry_o)
    );

endmodule

// ==== logic/log_arbiter.sv ====
`timescale 1ns/1ps

module log_arbiter #(
    parameter int N_CH      = 3,
    parameter int LOG_DEPTH = 16
) (
    input  logic                                  clk_i,
    input  logic                                  reset_ni,
    input  logic [N_CH-1:0]                       req_i,
    input  pss_peak_pkg::log_entry_t              entry_i [N_CH],
    input  logic [N_CH-1:0]                       drop_i,
    output logic [N_CH-1:0]                       ack_o,
    output logic                                  wr_en_o,
    output logic [$clog2(LOG_DEPTH)-1:0]          wr_addr_o,
    output pss_peak_pkg::log_entry_t              wr_data_o,
    output logic [$clog2(LOG_DEPTH+1)-1:0]        log_count_o,
    output logic [pss_peak_pkg::DROP_W-1:0]       dropped_o
);

    import pss_peak_pkg::*;

    localparam int GNT_W  = (N_CH > 1) ? $clog2(N_CH) : 1;
    localparam int ADDR_W = $clog2(LOG_DEPTH);
    localparam int CNT_W  = $clog2(LOG_DEPTH + 1);

    logic [GNT_W-1:0]   rr_ptr_q;
    logic [GNT_W-1:0]   gnt_q;
    logic [GNT_W-1:0]   pick;
    logic               pick_vld;
    logic [CNT_W-1:0]   fill_q;
    logic [DROP_W-1:0]  dropped_q;
    logic [DROP_W-1:0]  drop_add;
    logic               busy;
    logic               done;
    logic               log_full;
    logic               grant;

    assign busy     = |ack_o;
    assign done     = busy && !req_i[gnt_q];
    assign log_full = fill_q == CNT_W'(LOG_DEPTH);
    assign grant    = !busy && pick_vld;

    // first requester at or after the round-robin pointer
    always_comb begin
        int c;
        pick     = '0;
        pick_vld = 1'b0;
        for (int i = 0; i < N_CH; i++) begin
            c = int'(rr_ptr_q) + i;
            if (c >= N_CH) begin
                c = c - N_CH;
            end
            if (!pick_vld && req_i[c]) begin
                pick     = GNT_W'(c);
                pick_vld = 1'b1;
            end
        end
    end

    // reporter drops plus an entry that found the log full
    always_comb begin
        drop_add = DROP_W'(done && log_full);
        for (int i = 0; i < N_CH; i++) begin
            drop_add = drop_add + DROP_W'(drop_i[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ack_o     <= '0;
            gnt_q     <= '0;
            rr_ptr_q  <= '0;
            fill_q    <= '0;
            dropped_q <= '0;
            wr_en_o   <= 1'b0;
        end else begin
            wr_en_o   <= 1'b0;
            dropped_q <= dropped_q + drop_add;
            if (grant) begin
                ack_o    <= N_CH'(1) << pick;
                gnt_q    <= pick;
                rr_ptr_q <= (pick == GNT_W'(N_CH - 1)) ? '0 : pick + 1'b1;
                // a full log still acknowledges, the entry is simply lost
                wr_en_o  <= !log_full;
            end else if (done) begin
                ack_o <= '0;
                if (!log_full) begin
                    fill_q <= fill_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            wr_addr_o <= fill_q[ADDR_W-1:0];
            wr_data_o <= entry_i[pick];
        end
    end

    assign log_count_o = fill_q;
    assign dropped_o   = dropped_q;

    a_ack_onehot: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        $onehot0(ack_o)
    );

endmodule

// ==== logic/peak_log_ram.sv ====
`timescale 1ns/1ps

module peak_log_ram #(
    parameter int LOG_DEPTH = 16
) (
    input  logic                          clk_i,
    input  logic                          wr_en_i,
    input  logic [$clog2(LOG_DEPTH)-1:0]  wr_addr_i,
    input  pss_peak_pkg::log_entry_t      wr_data_i,
    input  logic [$clog2(LOG_DEPTH)-1:0]  rd_addr_i,
    output pss_peak_pkg::log_entry_t      rd_data_o
);

    import pss_peak_pkg::*;

    logic [ENTRY_W-1:0] mem_q [LOG_DEPTH];

    // the memory only sees the raw word
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i.raw;
        end
    end

    // host read data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        rd_data_o.raw <= mem_q[rd_addr_i];
    end

endmodule

// ==== logic/pss_peak_top.sv ====
`timescale 1ns/1ps

module pss_peak_top #(
    parameter int WINDOW_LEN = 8,
    parameter int N_CH       = 3,
    parameter int LOG_DEPTH  = 16
) (
    input  logic                                  clk_i,
    input  logic                                  reset_ni,
    input  pss_peak_pkg::sample_t                 sample_i [N_CH],
    input  logic [N_CH-1:0]                       valid_i,
    output logic [N_CH-1:0]                       peak_o,
    input  logic [$clog2(LOG_DEPTH)-1:0]          rd_addr_i,
    output pss_peak_pkg::log_entry_t              rd_data_o,
    output logic [$clog2(LOG_DEPTH+1)-1:0]        log_count_o,
    output logic [pss_peak_pkg::DROP_W-1:0]       dropped_o
);

    import pss_peak_pkg::*;

    logic [SCORE_W-1:0]              det_score [N_CH];
    logic [N_CH-1:0]                 rep_req;
    logic [N_CH-1:0]                 rep_ack;
    logic [N_CH-1:0]                 rep_drop;
    log_entry_t                      rep_entry [N_CH];

    logic                            wr_en;
    logic [$clog2(LOG_DEPTH)-1:0]    wr_addr;
    log_entry_t                      wr_data;

    // one detector and reporter per sequence hypothesis
    for (genvar g = 0; g < N_CH; g++) begin : g_chan
        peak_detector #(
            .WINDOW_LEN (WINDOW_LEN)
        ) u_detector (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .sample_i (sample_i[g]),
            .valid_i  (valid_i[g]),
            .peak_o   (peak_o[g]),
            .score_o  (det_score[g])
        );

        peak_reporter #(
            .CHANNEL (g)
        ) u_reporter (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .valid_i  (valid_i[g]),
            .peak_i   (peak_o[g]),
            .score_i  (det_score[g]),
            .req_o    (rep_req[g]),
            .ack_i    (rep_ack[g]),
            .entry_o  (rep_entry[g]),
            .drop_o   (rep_drop[g])
        );
    end

    log_arbiter #(
        .N_CH      (N_CH),
        .LOG_DEPTH (LOG_DEPTH)
    ) u_arbiter (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .req_i       (rep_req),
        .entry_i     (rep_entry),
        .drop_i      (rep_drop),
        .ack_o       (rep_ack),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .log_count_o (log_count_o),
        .dropped_o   (dropped_o)
    );

    peak_log_ram #(
        .LOG_DEPTH (LOG_DEPTH)
    ) u_log_ram (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

endmodule

// ==== dv/peak_cases.svh ====
// one row per spike event, applied in order
//   mask      channels that take the spike on the same cycle
//   pre       flat samples before the spike, 0 for a full window
//   base      level of the flat samples, never above the noise floor
//   spike     spike sample, exp_peak and exp_score are what it must give
//   spike2    second spike on the very next sample or 0, only after a logged peak
// a flat window of level b gives a threshold of 16 * b for any window length
typedef struct {
    int mask;
    int pre;
    int base;
    int spike;
    bit exp_peak;
    int exp_score;
    int spike2;
    bit exp_peak2;
} peak_case_t;

localparam int N_CASES = 14;

peak_case_t cases [N_CASES] = '{
    '{1, 2,  10,  5000, 0,     0,    0, 0},
    '{1, 0,  16,  1000, 1,   744,    0, 0},
    '{2, 0,  20,  4000, 1,  3680,    0, 0},
    '{4, 0,   4,   200, 0,     0,    0, 0},
    '{4, 0,   4,   256, 0,     0,    0, 0},
    '{4, 0,  32,   512, 0,     0,    0, 0},
    '{7, 0,   8,  3000, 1,  2872,    0, 0},
    '{2, 0,   0,   300, 1,   300, 2000, 1},
    '{7, 0,  12,  1200, 1,  1008,    0, 0},
    '{7, 0,  50,  9000, 1,  8200,    0, 0},
    '{7, 0, 100, 20000, 1, 18400,    0, 0},
    '{1, 0, 256, 65535, 1, 61439,    0, 0},
    '{4, 0,  40,   700, 1,    60,    0, 0},
    '{2, 0,   1,   300, 1,   284,    0, 0}
};

// ==== dv/pss_peak_tb.sv ====
`timescale 1ns/1ps

module pss_peak_tb;

    import pss_peak_pkg::*;

    localparam int WINDOW_LEN = 8;
    localparam int N_CH       = 3;
    localparam int LOG_DEPTH  = 16;
    localparam int ADDR_W     = $clog2(LOG_DEPTH);
    localparam int CNT_W      = $clog2(LOG_DEPTH + 1);
    localparam int CLK_PERIOD = 8;

    `include "peak_cases.svh"

    localparam int SETTLE_LIMIT    = 40;
    localparam int ROW_CYCLES      = WINDOW_LEN + 4 + SETTLE_LIMIT;
    localparam int READ_CYCLES     = 2 * LOG_DEPTH;
    localparam int WATCHDOG_CYCLES = (N_CASES * ROW_CYCLES + READ_CYCLES) * 4;

    logic               clk;
    logic               reset_n;
    sample_t            sample [N_CH];
    logic [N_CH-1:0]    valid;
    logic [N_CH-1:0]    peak;
    logic [ADDR_W-1:0]  rd_addr;
    log_entry_t         rd_data;
    logic [CNT_W-1:0]   log_count;
    logic [DROP_W-1:0]  dropped;

    logic [N_CH-1:0]    peak_exp;
    int                 seed;
    int                 n_checks;
    int                 n_errors;
    int                 exp_logged;
    int                 exp_dropped;
    int                 cnt [N_CH];
    int                 last_idx [N_CH];
    log_entry_t         exp_q [$];

    pss_peak_top #(
        .WINDOW_LEN (WINDOW_LEN),
        .N_CH       (N_CH),
        .LOG_DEPTH  (LOG_DEPTH)
    ) dut0 (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .sample_i    (sample),
        .valid_i     (valid),
        .peak_o      (peak),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .log_count_o (log_count),
        .dropped_o   (dropped)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // one valid sample on every channel, masked channels take the given value
    task automatic drive_cycle(input int mask, input int value, input bit is_peak);
        @(posedge clk);
        #1;
        check_value("peak_o", 32'(peak), 32'(peak_exp));
        for (int ch = 0; ch < N_CH; ch++) begin
            if (mask[ch]) begin
                sample[ch] = sample_t'(value);
            end else begin
                // filler stays below the noise floor and can never peak
                sample[ch] = sample_t'($random(seed) & (NOISE_LIMIT - 1));
            end
            last_idx[ch] = cnt[ch];
            cnt[ch] = (cnt[ch] + 1) % (2 ** TS_W);
        end
        valid = '1;
        peak_exp = is_peak ? N_CH'(mask) : '0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        check_value("peak_o", 32'(peak), 32'(peak_exp));
        valid = '0;
        peak_exp = '0;
    endtask

    // entries beyond the log depth are still acknowledged but only counted
    task automatic expect_entries(input int mask, input int score);
        log_entry_t e;
        for (int ch = 0; ch < N_CH; ch++) begin
            if (mask[ch]) begin
                if (exp_logged < LOG_DEPTH) begin
                    e.fld.chan  = CH_W'(ch);
                    e.fld.index = TS_W'(last_idx[ch]);
                    e.fld.score = SCORE_W'(score);
                    exp_q.push_back(e);
                    exp_logged++;
                end else begin
                    exp_dropped++;
                end
            end
        end
    endtask

    // every handled peak ends as either a log entry or a dropped event
    task automatic settle_counts();
        int waited;
        waited = 0;
        while (int'(log_count) + int'(dropped) != exp_logged + exp_dropped
               && waited < SETTLE_LIMIT) begin
            idle_cycle();
            waited++;
        end
        if (waited == SETTLE_LIMIT) begin
            n_errors++;
            $display("log and dropped counts did not settle within %0d cycles", SETTLE_LIMIT);
        end
        repeat (2) idle_cycle();
        check_value("log_count_o", 32'(log_count), 32'(exp_logged));
        check_value("dropped_o", 32'(dropped), 32'(exp_dropped));
    endtask

    task automatic run_case(input int r);
        peak_case_t c;
        int n_pre;
        c = cases[r];
        n_pre = (c.pre == 0) ? WINDOW_LEN : c.pre;
        repeat (n_pre) drive_cycle(c.mask, c.base, 1'b0);
        drive_cycle(c.mask, c.spike, c.exp_peak);
        if (c.exp_peak) begin
            expect_entries(c.mask, c.exp_score);
        end
        if (c.spike2 != 0) begin
            drive_cycle(c.mask, c.spike2, c.exp_peak2);
            // the reporter is still busy with the first peak
            if (c.exp_peak2) begin
                exp_dropped += $countones(c.mask);
            end
        end
        settle_counts();
    endtask

    // log order across channels is free, so each entry is matched by channel and index
    task automatic match_entry(input log_entry_t e);
        int hit;
        hit = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (hit < 0 && exp_q[i].fld.chan == e.fld.chan
                && exp_q[i].fld.index == e.fld.index) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            n_errors++;
            $display("log entry 0x%08h matches no expected detection", e.raw);
        end else begin
            check_value("rd_data_o.score", 32'(e.fld.score), 32'(exp_q[hit].fld.score));
            exp_q.delete(hit);
        end
    endtask

    task automatic read_log();
        int n_read;
        n_read = exp_logged;
        for (int a = 0; a < n_read; a++) begin
            @(posedge clk);
            #1;
            rd_addr = ADDR_W'(a);
            @(posedge clk);
            #1;
            match_entry(rd_data);
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%0d expected detections are missing from the log", exp_q.size());
        end
    endtask

    initial begin
        seed        = 32'he59547bf;
        n_checks    = 0;
        n_errors    = 0;
        exp_logged  = 0;
        exp_dropped = 0;
        peak_exp    = '0;
        reset_n     = 1'b0;
        valid       = '0;
        rd_addr     = '0;
        for (int ch = 0; ch < N_CH; ch++) begin
            sample[ch]   = '0;
            cnt[ch]      = 0;
            last_idx[ch] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int r = 0; r < N_CASES; r++) begin
            run_case(r);
        end
        read_log();
        // the table overflows the log, so it must end exactly full
        check_value("log_count_o", 32'(log_count), 32'(LOG_DEPTH));

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== pss_peak_top.f ====
+incdir+dv
logic/pss_peak_pkg.sv
logic/peak_detector.sv
logic/peak_reporter.sv
logic/log_arbiter.sv
logic/peak_log_ram.sv
logic/pss_peak_top.sv
dv/pss_peak_tb.sv
